/* bench/fir_chk.sv */
module fir_chk (
   input logic          clk,
   input logic          rst,
   input logic          en,
   input logic          in_valid,
   input logic          out_valid,
   input fir_pkg::acc_t out_result,
   input fir_pkg::tag_t out_tag
);

   import fir_pkg::*;

   // accepts seen at the ports, shifted on enabled edges only, so the
   // top bit marks an accept exactly pipe_latency enabled cycles back
   logic [pipe_latency-1:0] accept_hist;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         accept_hist <= '0;
      end else if (en) begin
         accept_hist <= {accept_hist[pipe_latency-2:0], in_valid};
      end
   end

   // a valid output needs its own accepted sample behind it
   a_valid_has_accept: assert property (@(posedge clk) disable iff (rst)
      out_valid |-> accept_hist[pipe_latency-1])
   else $error("out_valid high without an accept %0d enabled cycles earlier", pipe_latency);

   // and no accepted sample is dropped on the way
   a_accept_not_lost: assert property (@(posedge clk) disable iff (rst)
      accept_hist[pipe_latency-1] |-> out_valid)
   else $error("accepted sample did not reach out_valid after %0d enabled cycles",
               pipe_latency);

   // a stalled edge leaves every output as it was
   a_stall_holds: assert property (@(posedge clk) disable iff (rst)
      !en |=> $stable(out_result) && $stable(out_valid) && $stable(out_tag))
   else $error("outputs changed across a stalled cycle");

   a_reset_clears_valid: assert property (@(posedge clk) rst |-> !out_valid)
   else $error("out_valid high while rst is asserted");

endmodule

bind fir_top fir_chk u_fir_chk (
   .clk        (clk),
   .rst        (rst),
   .en         (en),
   .in_valid   (in_valid),
   .out_valid  (out_valid),
   .out_result (out_result),
   .out_tag    (out_tag)
);

/* bench/fir_tb.sv */
module fir_tb;

   import fir_pkg::*;

   // filter coefficients of the DUT where coefs[0] scales the newest sample
   localparam coef_vec_t tb_coefs = '{16'sd3, -16'sd5, 16'sd7, 16'sd2};

   // reset length in clock cycles
   localparam int reset_cycles = 8;

   // idle enabled cycles after the table, enough to flush the pipeline
   localparam int drain_cycles = pipe_latency + 4;

   // extra cycles on top of the expected run length before giving up
   localparam int timeout_margin = 20;

   logic    clk = 1'b0;
   logic    rst;
   logic    en;
   logic    in_valid;
   sample_t in_sample;
   tag_t    in_tag;
   logic    out_valid;
   acc_t    out_result;
   tag_t    out_tag;

   // stimulus table with one entry per clock cycle
   string   row_name [$];
   bit      row_en [$];
   bit      row_valid [$];
   sample_t row_sample [$];
   tag_t    row_tag [$];
   // rows with has_exp set also carry the result the filter must give
   bit      row_has_exp [$];
   int      row_exp [$];

   // reference coefficients and history of accepted samples, newest first
   longint  coef_ref [taps];
   longint  hist [taps];

   // expected outputs in acceptance order, with the enabled edge that
   // must take each one
   string   exp_name [$];
   longint  exp_result [$];
   tag_t    exp_tag [$];
   int      exp_edge [$];

   // enabled edges since reset, and the en value of the last driven row
   int      en_edges;
   bit      prev_en;
   tag_t    next_tag;
   int      errors;
   int      checks;
   int      cycle_count = 0;
   int      cycle_limit = 0;

   fir_top #(
      .coefs (tb_coefs)
   ) u_fir_top (
      .clk        (clk),
      .rst        (rst),
      .en         (en),
      .in_valid   (in_valid),
      .in_sample  (in_sample),
      .in_tag     (in_tag),
      .out_valid  (out_valid),
      .out_result (out_result),
      .out_tag    (out_tag)
   );

   always #20 clk = ~clk;

   // compare one value and report it when it differs
   task automatic check_value(string name, longint expected, longint actual);
      checks++;
      if (expected != actual) begin
         errors++;
         $display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
      end
   endtask

   // append one row to the stimulus table
   task automatic add_row(string name, bit en_v, bit valid_v, sample_t sample_v,
                          bit has_exp, int exp_v);
      tag_t tag_v;
      // accepted samples get consecutive tags and the others a dummy tag
      tag_v = 4'hf;
      if (en_v && valid_v) begin
         tag_v = next_tag;
         next_tag = next_tag + 4'd1;
      end
      row_name.push_back(name);
      row_en.push_back(en_v);
      row_valid.push_back(valid_v);
      row_sample.push_back(sample_v);
      row_tag.push_back(tag_v);
      row_has_exp.push_back(has_exp);
      row_exp.push_back(exp_v);
   endtask

   task automatic add_sample(string name, sample_t sample_v);
      add_row(name, 1'b1, 1'b1, sample_v, 1'b0, 0);
   endtask

   task automatic build_table();
      bit en_v;
      bit valid_v;
      int unsigned r;
      // a lone 1 reads the coefficients back one by one, then zero
      add_row("impulse", 1'b1, 1'b1, 16'sd1, 1'b1, 3);
      add_row("impulse", 1'b1, 1'b1, 16'sd0, 1'b1, -5);
      add_row("impulse", 1'b1, 1'b1, 16'sd0, 1'b1, 7);
      add_row("impulse", 1'b1, 1'b1, 16'sd0, 1'b1, 2);
      add_row("impulse", 1'b1, 1'b1, 16'sd0, 1'b1, 0);
      // full-scale plateaus, then alternating extremes for the largest sums
      for (int i = 0; i < 4; i++) begin
         add_row("extremes", 1'b1, 1'b1, 16'sh8000, i == 3, -229376);
      end
      for (int i = 0; i < 4; i++) begin
         add_row("extremes", 1'b1, 1'b1, 16'sh7fff, i == 3, 229369);
      end
      add_sample("extremes", 16'sh8000);
      add_sample("extremes", 16'sh7fff);
      add_row("extremes", 1'b1, 1'b1, 16'sh8000, 1'b1, -425981);
      add_row("extremes", 1'b1, 1'b1, 16'sh7fff, 1'b1, 425974);
      // idle rows carry junk samples that must never reach the history
      add_sample("gaps", 16'sd100);
      add_row("gaps", 1'b1, 1'b0, 16'sd999, 1'b0, 0);
      add_row("gaps", 1'b1, 1'b0, -16'sd999, 1'b0, 0);
      add_sample("gaps", -16'sd200);
      add_row("gaps", 1'b1, 1'b0, -16'sd7, 1'b0, 0);
      add_sample("gaps", 16'sd50);
      add_row("gaps", 1'b1, 1'b1, 16'sd25, 1'b1, -1375);
      // stalled rows, some with in_valid high, freeze results in flight
      add_sample("stall", 16'sd1000);
      add_sample("stall", 16'sd2000);
      add_row("stall", 1'b0, 1'b1, 16'sd1234, 1'b0, 0);
      add_row("stall", 1'b0, 1'b0, 16'sd0, 1'b0, 0);
      add_row("stall", 1'b0, 1'b1, -16'sd4321, 1'b0, 0);
      add_sample("stall", -16'sd3000);
      add_row("stall", 1'b0, 1'b0, 16'sd0, 1'b0, 0);
      add_row("stall", 1'b1, 1'b1, 16'sd4000, 1'b1, 43000);
      for (int i = 0; i < 3; i++) begin
         add_row("stall", 1'b0, 1'b1, 16'sd77, 1'b0, 0);
      end
      // a long back-to-back run wraps the 4-bit tag
      for (int k = 0; k < 18; k++) begin
         add_sample("tags", sample_t'(k * 37 - 300));
      end
      // random samples with random gaps and stalls
      for (int k = 0; k < 48; k++) begin
         en_v = ($urandom % 4) != 0;
         valid_v = ($urandom % 3) != 0;
         r = $urandom;
         add_row("random", en_v, valid_v, r[15:0], 1'b0, 0);
      end
   endtask

   // the reference model runs for each accepted row as that row is driven
   task automatic model_accept(int row);
      longint sum;
      for (int i = taps - 1; i > 0; i--) begin
         hist[i] = hist[i-1];
      end
      hist[0] = longint'(row_sample[row]);
      sum = 0;
      for (int i = 0; i < taps; i++) begin
         sum += coef_ref[i] * hist[i];
      end
      if (row_has_exp[row]) begin
         check_value({row_name[row], " table"}, longint'(row_exp[row]), sum);
      end
      exp_name.push_back(row_name[row]);
      exp_result.push_back(sum);
      exp_tag.push_back(row_tag[row]);
      // the next edge accepts, and pipe_latency enabled edges later the
      // consumer takes the result
      exp_edge.push_back(en_edges + 1 + pipe_latency);
   endtask

   // drive one row at the rising edge and count the edge if it was enabled
   task automatic drive_row(bit en_v, bit valid_v, sample_t sample_v, tag_t tag_v);
      @(posedge clk);
      if (prev_en) begin
         en_edges++;
      end
      en <= en_v;
      in_valid <= valid_v;
      in_sample <= sample_v;
      in_tag <= tag_v;
      prev_en = en_v;
   endtask

   // outputs are read mid-cycle, and a result counts only when the
   // coming edge is enabled
   task automatic score_outputs();
      @(negedge clk);
      if (en && out_valid) begin
         if (exp_result.size() == 0) begin
            errors++;
            $display("unexpected output: out_valid is high but no result is pending");
         end else begin
            check_value({exp_name[0], " result"}, exp_result[0], longint'(out_result));
            check_value({exp_name[0], " tag"}, longint'(exp_tag[0]), longint'(out_tag));
            check_value({exp_name[0], " latency"}, longint'(exp_edge[0]),
                        longint'(en_edges + 1));
            void'(exp_name.pop_front());
            void'(exp_result.pop_front());
            void'(exp_tag.pop_front());
            void'(exp_edge.pop_front());
         end
      end
   endtask

   // ends a run that has stopped making progress
   always @(posedge clk) begin
      cycle_count++;
      if (cycle_limit != 0 && cycle_count > cycle_limit) begin
         $display("timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("TEST FAILED");
         $finish;
      end
   end

   initial begin
      int drain;
      int total_errors;
      void'($urandom(32'h25f9_5f7d));
      errors = 0;
      checks = 0;
      en_edges = 0;
      prev_en = 1'b0;
      next_tag = '0;
      coef_ref = '{64'sd3, -64'sd5, 64'sd7, 64'sd2};
      for (int i = 0; i < taps; i++) begin
         hist[i] = 0;
      end
      rst <= 1'b1;
      en <= 1'b0;
      in_valid <= 1'b0;
      in_sample <= '0;
      in_tag <= '0;
      build_table();
      cycle_limit = reset_cycles + row_en.size() + pipe_latency + drain_cycles
                    + timeout_margin;
      repeat (reset_cycles) @(posedge clk);
      rst <= 1'b0;
      for (int i = 0; i < row_en.size(); i++) begin
         drive_row(row_en[i], row_valid[i], row_sample[i], row_tag[i]);
         if (row_en[i] && row_valid[i]) begin
            model_accept(i);
         end
         score_outputs();
      end
      // keep the pipeline running until every expected result is back
      drain = 0;
      while (exp_result.size() != 0 && drain < drain_cycles) begin
         drive_row(1'b1, 1'b0, '0, '0);
         score_outputs();
         drain++;
      end
      total_errors = errors;
      if (exp_result.size() != 0) begin
         total_errors += exp_result.size();
         $display("missing output: %0d expected results never came out, first from %s",
                  exp_result.size(), exp_name[0]);
      end
      $display("checks %0d, errors %0d", checks, total_errors);
      if (total_errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* hdl/delay.sv */
module delay #(
   // payload type carried through the line
   parameter type data_t = logic,
   // number of enabled cycles the payload is held back
   parameter int cycles = 1,
   // value every stage takes during reset
   parameter data_t reset_value = '0
) (
   input  logic  clk,
   input  logic  rst,
   input  logic  en,
   input  data_t d,
   output data_t q
);

   // a negative delay has no meaning, so elaboration is stopped here
   // with a message that names the offending parameter
   if (cycles < 0) begin : g_bad_cycles
      $fatal(1, "delay: parameter cycles must be >= 0, got %0d", cycles);
   end

   // zero cycles turns the line into a plain wire
   else if (cycles == 0) begin : g_wire
      assign q = d;
   end

   // one register per cycle of delay
   else begin : g_chain

      // stage[0] is the line input and stage[i+1] is the output of
      // register i, so the array needs one more entry than there are
      // registers
      data_t stage [cycles+1];

      // head of the chain comes straight from the input port
      assign stage[0] = d;

      // every register shares clk, rst and en, so a stall freezes the
      // whole line at once and nothing inside it is lost or doubled
      for (genvar i = 0; i < cycles; i++) begin : g_stage
         register #(
            .data_t      (data_t),
            .reset_value (reset_value)
         ) u_register (
            .clk (clk),
            .rst (rst),
            .en  (en),
            .d   (stage[i]),
            .q   (stage[i+1])
         );
      end

      // tail of the chain drives the output
      assign q = stage[cycles];

   end

   // after reset the output shows reset_value until cycles enabled edges
   // have passed, then it shows the input from cycles enabled edges ago
   // cycles with en low are not counted, since no stage moves on them

endmodule

/* hdl/fir_pkg.sv */
package fir_pkg;

   // number of filter taps, which is also the depth of the sample history
   localparam int taps = 4;

   // input samples and coefficients are both signed 16-bit fixed point
   typedef logic signed [15:0] sample_t;
   typedef logic signed [15:0] coef_t;

   // one coefficient per tap, index 0 multiplies the newest sample
   typedef coef_t coef_vec_t [taps];

   // a full 16x16 signed product fits in 32 bits, since the only
   // magnitude that needs bit 31 is -32768 * -32768 = 2^30
   typedef logic signed [31:0] product_t;

   // two extra bits cover the sum of four worst-case products, so the
   // adder stage never wraps and needs no saturation
   typedef logic signed [33:0] acc_t;

   // sequence tag that rides along with each sample
   typedef logic [3:0] tag_t;

   // enabled cycles from an accepted input to its result:
   // tap register, multiply register, adder register
   localparam int pipe_latency = 3;

   // the valid and tag delay lines are sized from this value, so it must
   // match the number of register stages between in_sample and out_result

endpackage

/* hdl/fir_top.sv */
module fir_top #(
   // filter coefficients, passed down to the multiply-accumulate pipe
   parameter fir_pkg::coef_vec_t coefs = '{default: '0}
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             en,
   input  logic             in_valid,
   input  fir_pkg::sample_t in_sample,
   input  fir_pkg::tag_t    in_tag,
   output logic             out_valid,
   output fir_pkg::acc_t    out_result,
   output fir_pkg::tag_t    out_tag
);

   import fir_pkg::*;

   // high on the edge where a sample enters the filter
   logic accept;

   // current sample history from the tap line
   sample_t taps_q [taps];

   assign accept = in_valid & en;

   // first stage, the sample history
   tap_line u_tap_line (
      .clk       (clk),
      .rst       (rst),
      .en        (en),
      .in_valid  (in_valid),
      .in_sample (in_sample),
      .taps_q    (taps_q)
   );

   // second and third stages, products and their sum
   mac_pipe #(
      .coefs (coefs)
   ) u_mac_pipe (
      .clk    (clk),
      .rst    (rst),
      .en     (en),
      .taps_q (taps_q),
      .result (out_result)
   );

   // the accept pulse walks through as many enabled stages as the data,
   // so out_valid marks exactly the cycles that hold a new result
   delay #(
      .data_t      (logic),
      .cycles      (pipe_latency),
      .reset_value (1'b0)
   ) u_valid_delay (
      .clk (clk),
      .rst (rst),
      .en  (en),
      .d   (accept),
      .q   (out_valid)
   );

   // tag moves on every enabled edge like the valid bit does, which keeps
   // it next to its own sample's result
   delay #(
      .data_t      (tag_t),
      .cycles      (pipe_latency),
      .reset_value ('0)
   ) u_tag_delay (
      .clk (clk),
      .rst (rst),
      .en  (en),
      .d   (in_tag),
      .q   (out_tag)
   );

endmodule

/* hdl/mac_pipe.sv */
module mac_pipe #(
   // one coefficient per tap, coefs[0] scales the newest sample
   parameter fir_pkg::coef_vec_t coefs = '{default: '0}
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             en,
   input  fir_pkg::sample_t taps_q [fir_pkg::taps],
   output fir_pkg::acc_t    result
);

   import fir_pkg::*;

   // combinational products of each tap with its coefficient
   product_t prod_d [taps];

   // registered products, the second pipeline stage
   product_t prod_q [taps];

   // combinational sum of the registered products
   acc_t sum_d;

   // multiply stage
   // both operands are widened to product_t before the multiply so the
   // signed product is formed at full width
   always_comb begin
      for (int i = 0; i < taps; i++) begin
         prod_d[i] = product_t'(taps_q[i]) * product_t'(coefs[i]);
      end
   end

   // products are captured on every enabled edge, whether or not a new
   // sample was accepted, because the valid delay line decides which
   // results count
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < taps; i++) begin
            prod_q[i] <= '0;
         end
      end else if (en) begin
         for (int i = 0; i < taps; i++) begin
            prod_q[i] <= prod_d[i];
         end
      end
   end

   // adder stage
   // each product is sign-extended into acc_t before it is added, so
   // the running sum keeps the full range of four products
   always_comb begin
      sum_d = '0;
      for (int i = 0; i < taps; i++) begin
         sum_d = sum_d + acc_t'(prod_q[i]);
      end
   end

   // the sum is registered as the third and last pipeline stage
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         result <= '0;
      end else if (en) begin
         result <= sum_d;
      end
   end

   // timing from taps_q to result
   // edge 1 loads prod_q from the taps, edge 2 loads result from prod_q
   // both stages use the same en, so during a stall prod_q may hold one
   // sample's products while result holds the previous sample's sum,
   // and both move on together once en returns

   // worst case check of the widths
   // a single product is at most 2^30 in magnitude, four of them sum to
   // at most 2^32, which is inside the signed 34-bit range of acc_t

   // the tree here is a plain linear sum, which is enough for four taps
   // at the expected clock rates, a wider filter would want the adder
   // split over more registered levels and pipe_latency raised to match

endmodule

/* hdl/register.sv */
module register #(
   // payload type, any packed type works
   parameter type data_t = logic,
   // value loaded while rst is high
   parameter data_t reset_value = '0
) (
   input  logic  clk,
   input  logic  rst,
   input  logic  en,
   input  data_t d,
   output data_t q
);

   // single storage element of every delay stage in the design
   // rst is asynchronous and active high, so it acts without a clock edge
   // en low makes the register hold, which is how the pipeline stalls
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         // back to the known value, independent of en
         q <= reset_value;
      end else if (en) begin
         q <= d;
      end
      // no else branch: with en low the register keeps its old contents
   end

endmodule

/* hdl/tap_line.sv */
module tap_line (
   input  logic             clk,
   input  logic             rst,
   input  logic             en,
   input  logic             in_valid,
   input  fir_pkg::sample_t in_sample,
   output fir_pkg::sample_t taps_q [fir_pkg::taps]
);

   import fir_pkg::*;

   // a sample only enters the history on an edge where it is offered
   // and the pipeline is running
   logic accept;

   assign accept = in_valid & en;

   // history of the last taps accepted samples, newest at index 0
   // this register is the first of the pipe_latency stages
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         // an empty history reads as zeros, so the first outputs after
         // reset only see the samples that have really arrived
         for (int i = 0; i < taps; i++) begin
            taps_q[i] <= '0;
         end
      end else if (accept) begin
         // new sample goes in at the front
         taps_q[0] <= in_sample;
         // older samples move one place toward the end, the oldest
         // falls off the last tap
         for (int i = 1; i < taps; i++) begin
            taps_q[i] <= taps_q[i-1];
         end
      end
      // idle cycles between samples leave the history alone, so a gap
      // in in_valid never pushes zeros into the filter
   end

   // note that a stall and an idle cycle look the same here, in both
   // cases accept is low and the history holds

endmodule

/* list.f */
hdl/fir_pkg.sv
hdl/register.sv
hdl/delay.sv
hdl/tap_line.sv
hdl/mac_pipe.sv
hdl/fir_top.sv
bench/fir_chk.sv
bench/fir_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the FIR testbench with Verilator and runs it
# the run passes only if the testbench prints its pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module fir_tb -Mdir obj_dir -f list.f \
   && ./obj_dir/Vfir_tb | tee /dev/stderr | grep -x "TEST PASSED" > /dev/null \
   && echo "simulation passed" \
   && exit 0 \
   || { echo "simulation failed"; exit 1; }
